// File: files.f
logic/pe_pkg.sv
logic/pe_alu.sv
logic/pe_decode.sv
logic/pe_regfile.sv
logic/pe_lsu.sv
logic/pe_imem.sv
logic/pe_control.sv
logic/pe_core.sv
verif/tb_pe_clock.sv
verif/tb_pe_core.sv

// File: Bender.yml
package:
  name: pe_core

sources:
  - logic/pe_pkg.sv
  - logic/pe_alu.sv
  - logic/pe_decode.sv
  - logic/pe_regfile.sv
  - logic/pe_lsu.sv
  - logic/pe_imem.sv
  - logic/pe_control.sv
  - logic/pe_core.sv
  - target: test
    files:
      - verif/tb_pe_clock.sv
      - verif/tb_pe_core.sv

// File: verif/tb_pe_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pe_core;

    import pe_pkg::*;

    localparam int n_pe       = 16;
    localparam int pe_id      = 2;
    localparam int wait_limit = 200;

    logic            clk;
    logic            rst;
    logic            restart;
    logic            inst_en;
    imem_wr_t        imem_wr;
    logic [n_pe-1:0] grid_state;
    wb_req_t         wb_req;
    wb_rsp_t         wb_rsp;
    logic [31:0]     link;
    logic            trap;
    logic            busy;

    int          checks;
    int          mismatches;
    int          timeouts;
    logic [31:0] prog [$];
    logic [31:0] link_exp [$];

    // wishbone slave memory, word indexed, tagged with the full address
    logic [31:0] wb_mem [256];
    logic [31:0] wb_tag [256];
    logic        wb_written [256];
    int          st_count;
    int          ld_count;
    logic [31:0] st_adr;
    logic [31:0] st_dat;
    logic [3:0]  st_sel;

    tb_pe_clock #(.period_ns(8), .reset_cycles(3)) u_clock (
        .i_restart (restart),
        .clk       (clk),
        .rst       (rst)
    );

    pe_core #(
        .n_pe       (n_pe),
        .pe_id      (pe_id),
        .reset_pc   (0),
        .imem_depth (1024)
    ) dut0 (
        .clk          (clk),
        .rst          (rst),
        .i_inst_en    (inst_en),
        .i_imem_wr    (imem_wr),
        .i_grid_state (grid_state),
        .i_wb         (wb_rsp),
        .o_wb         (wb_req),
        .o_link       (link),
        .o_trap       (trap),
        .o_busy       (busy)
    );

    // ------------------------------
    // instruction encoders
    // ------------------------------

    function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [2:0] f3,
                                               input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] lw_word(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // content of a word never stored
    function automatic logic [31:0] fill_word(input logic [31:0] adr);
        return (adr * 32'h9E37_79B1) ^ 32'h5EED_C0DE;
    endfunction

    // ------------------------------
    // common tasks
    // ------------------------------

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("Fail: %s is 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("timeout: %s at %0t", what, $time);
    endtask

    task automatic step_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic restart_dut;
        int n;
        inst_en    = 1'b0;
        grid_state = '0;
        imem_wr    = '0;
        step_cycle();
        restart = 1'b1;
        step_cycle();
        restart = 1'b0;
        n = 0;
        while (rst && n < 10) begin
            step_cycle();
            n++;
        end
        if (rst) begin
            report_timeout("reset was never released");
        end
    endtask

    // preload port is only honoured while the core is idle
    task automatic load_program;
        foreach (prog[i]) begin
            imem_wr.we   = 1'b1;
            imem_wr.addr = 14'(i);
            imem_wr.data = prog[i];
            step_cycle();
        end
        imem_wr = '0;
    endtask

    task automatic wait_link_change(input string what);
        logic [31:0] prev;
        int          n;
        prev = link;
        n    = 0;
        while (link === prev && n < wait_limit) begin
            step_cycle();
            n++;
        end
        if (link === prev) begin
            report_timeout(what);
        end
    endtask

    task automatic wait_trap(input string what);
        int n;
        n = 0;
        while (!trap && n < wait_limit) begin
            step_cycle();
            n++;
        end
        if (!trap) begin
            report_timeout(what);
        end
    endtask

    // ------------------------------
    // tests
    // ------------------------------

    task automatic test_reset;
        int n;
        n = 0;
        // rst is still unknown at time zero
        while (rst !== 1'b0 && n < 10) begin
            step_cycle();
            n++;
        end
        if (rst !== 1'b0) begin
            report_timeout("initial reset was never released");
        end
        compare("o_trap", 32'(trap), 32'd0);
        compare("o_busy", 32'(busy), 32'd0);
        compare("o_link", link, 32'd0);
        compare("o_wb.cyc", 32'(wb_req.cyc), 32'd0);
        compare("o_wb.stb", 32'(wb_req.stb), 32'd0);
    endtask

    task automatic test_arith;
        logic [31:0] x1;
        logic [31:0] x2;
        logic [31:0] x3;
        logic [31:0] x4;
        logic [31:0] x5;
        logic [31:0] x6;
        logic [31:0] x7;
        logic [31:0] x8;
        restart_dut();
        x1 = {20'hABCDE, 12'h000};
        x2 = 32'h0000_05A3;
        // addi with -16
        x3 = x1 + 32'hFFFF_FFF0;
        x4 = x1 + x2;
        x5 = x4 - x3;
        x6 = x5 ^ x1;
        x7 = x6 | x3;
        x8 = x7 & x4;
        link_exp = '{x1, x2, x3, x4, x5, x6, x7, x8};
        prog = '{lui_word(1, 20'hABCDE), addi_word(2, 0, 12'h5A3), addi_word(3, 1, 12'hFF0),
                 rtype_word(7'h00, 3'b000, 4, 1, 2), rtype_word(7'h20, 3'b000, 5, 4, 3),
                 rtype_word(7'h00, 3'b100, 6, 5, 1), rtype_word(7'h00, 3'b110, 7, 6, 3),
                 rtype_word(7'h00, 3'b111, 8, 7, 4), 32'h0};
        load_program();
        inst_en = 1'b1;
        // idle, fetch, exec, then two cycles per instruction
        repeat (3) step_cycle();
        foreach (link_exp[k]) begin
            if (k > 0) begin
                repeat (2) step_cycle();
            end
            compare("o_link", link, link_exp[k]);
        end
        wait_trap("arithmetic program did not reach its trap");
    endtask

    task automatic test_branch;
        logic [31:0] exp;
        restart_dut();
        // beq skips the first add, bne falls through to the second
        exp  = 32'h40 + 32'h202;
        prog = '{addi_word(1, 0, 12'h005), addi_word(2, 0, 12'h005), addi_word(3, 0, 12'h040),
                 branch_word(3'b000, 1, 2, 13'd8), addi_word(3, 3, 12'h111),
                 branch_word(3'b001, 1, 2, 13'd8), addi_word(3, 3, 12'h202), 32'h0};
        load_program();
        inst_en = 1'b1;
        wait_trap("branch program did not reach its trap");
        compare("o_link", link, exp);
    endtask

    task automatic test_memory;
        logic [31:0] base;
        logic [31:0] data;
        base     = 32'h0000_1000;
        data     = {20'hCAFE1, 12'h000} + 32'h234;
        st_count = 0;
        ld_count = 0;
        restart_dut();
        prog = '{lui_word(1, 20'h00001), lui_word(2, 20'hCAFE1), addi_word(2, 2, 12'h234),
                 addi_word(5, 0, 12'h007), sw_word(2, 1, 12'h024), lw_word(3, 1, 12'h024),
                 lw_word(4, 1, 12'h040), 32'h0};
        link_exp = '{base, {20'hCAFE1, 12'h000}, data, 32'h7, data, fill_word(base + 32'h40)};
        load_program();
        inst_en = 1'b1;
        foreach (link_exp[k]) begin
            wait_link_change("memory program stopped writing registers");
            compare("o_link", link, link_exp[k]);
        end
        wait_trap("memory program did not reach its trap");
        compare("store count", 32'(st_count), 32'd1);
        compare("load count", 32'(ld_count), 32'd2);
        compare("o_wb.adr", st_adr, base + 32'h24);
        compare("o_wb.dat", st_dat, data);
        compare("o_wb.sel", 32'(st_sel), 32'hF);
        compare("o_busy", 32'(busy), 32'd0);
    endtask

    task automatic test_barrier;
        restart_dut();
        prog = '{addi_word(1, 0, 12'h011), addi_word(2, 0, 12'h022), 32'h0};
        load_program();
        grid_state[5] = 1'b1;
        inst_en       = 1'b1;
        repeat (20) begin
            step_cycle();
            compare("o_link", link, 32'd0);
        end
        grid_state = '0;
        wait_link_change("core stayed stalled after barrier release");
        compare("o_link", link, 32'h11);
        // own bit only
        grid_state[pe_id] = 1'b1;
        wait_link_change("core stalled on its own grid bit");
        compare("o_link", link, 32'h22);
        wait_trap("barrier program did not reach its trap");
        grid_state = '0;
    endtask

    task automatic test_trap;
        restart_dut();
        prog = '{addi_word(1, 0, 12'h055), 32'h0, addi_word(1, 0, 12'h066), 32'h0};
        load_program();
        inst_en = 1'b1;
        wait_trap("all-zero word did not raise o_trap");
        compare("o_link", link, 32'h55);
        repeat (20) begin
            step_cycle();
            compare("o_trap", 32'(trap), 32'd1);
            compare("o_link", link, 32'h55);
        end
    endtask

    // ------------------------------
    // wishbone slave model
    // ------------------------------

    task automatic serve_request;
        int idx;
        idx = int'(wb_req.adr[9:2]);
        if (wb_req.we) begin
            wb_mem[idx]     = wb_req.dat;
            wb_tag[idx]     = wb_req.adr;
            wb_written[idx] = 1'b1;
            st_count++;
            st_adr = wb_req.adr;
            st_dat = wb_req.dat;
            st_sel = wb_req.sel;
        end else begin
            ld_count++;
            if (wb_written[idx] && wb_tag[idx] == wb_req.adr) begin
                wb_rsp.dat = wb_mem[idx];
            end else begin
                wb_rsp.dat = fill_word(wb_req.adr);
            end
        end
        wb_rsp.ack = 1'b1;
    endtask

    initial begin : wb_slave
        int          delay;
        logic        pending;
        void'($urandom(32'h11698717));
        wb_rsp  = '0;
        pending = 1'b0;
        delay   = 0;
        forever begin
            step_cycle();
            if (rst) begin
                wb_rsp  = '0;
                pending = 1'b0;
            end else if (wb_rsp.ack) begin
                // master drops the cycle on the ack edge
                wb_rsp = '0;
            end else if (wb_req.cyc && wb_req.stb) begin
                compare("o_busy", 32'(busy), 32'd1);
                if (!pending) begin
                    pending = 1'b1;
                    delay   = int'($urandom % 6);
                end
                if (delay == 0) begin
                    serve_request();
                    pending = 1'b0;
                end else begin
                    delay--;
                end
            end
        end
    end

    // ------------------------------
    // main sequence
    // ------------------------------

    initial begin
        restart    = 1'b0;
        inst_en    = 1'b0;
        imem_wr    = '0;
        grid_state = '0;
        checks     = 0;
        mismatches = 0;
        timeouts   = 0;
        st_count   = 0;
        ld_count   = 0;
        foreach (wb_written[i]) begin
            wb_written[i] = 1'b0;
        end
        test_reset();
        test_arith();
        test_branch();
        test_memory();
        test_barrier();
        test_trap();
        $display("tb_pe_core: %0d checks, %0d mismatches, %0d timeouts",
                 checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/tb_pe_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pe_clock #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 3
) (
    input  wire logic i_restart,
    output logic      clk,
    output logic      rst
);

    // reset edges still to come
    int unsigned cnt;

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        cnt = reset_cycles;
    end

    // a restart request opens a new reset window of the same length
    always @(posedge clk) begin
        if (i_restart) begin
            rst <= 1'b1;
            cnt <= reset_cycles;
        end else if (cnt > 1) begin
            cnt <= cnt - 1;
        end else begin
            rst <= 1'b0;
            cnt <= 0;
        end
    end

endmodule

`default_nettype wire

// File: logic/pe_core.sv
`timescale 1ns/1ps
`default_nettype none

module pe_core #(
    parameter int n_pe       = 16,
    parameter int pe_id      = 0,
    parameter int reset_pc   = 0,
    parameter int imem_depth = 1024
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              i_inst_en,
    input  wire pe_pkg::imem_wr_t  i_imem_wr,
    input  wire logic [n_pe-1:0]   i_grid_state,
    input  wire pe_pkg::wb_rsp_t   i_wb,
    output pe_pkg::wb_req_t        o_wb,
    output logic [pe_pkg::xlen-1:0] o_link,
    output logic                   o_trap,
    output logic                   o_busy
);

    import pe_pkg::*;

    localparam int aw = $clog2(imem_depth);

    // instruction path
    logic [aw-1:0]   imem_addr;
    logic            fetch_en;
    logic            idle;
    logic [xlen-1:0] imem_rdata;
    logic [xlen-1:0] instr;
    decoded_t        dec;

    // execute path
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] alu_result;
    logic            alu_zero;

    // write back and memory
    logic            rf_we;
    logic [4:0]      rf_waddr;
    logic [xlen-1:0] rf_wdata;
    logic            mem_start;
    logic            mem_done;
    logic [xlen-1:0] load_data;

    // second operand is the immediate for lui, op-imm and address generation
    assign alu_b = dec.use_imm ? dec.imm : rs2_data;

    pe_control #(
        .n_pe       (n_pe),
        .pe_id      (pe_id),
        .reset_pc   (reset_pc),
        .imem_depth (imem_depth)
    ) u_control (
        .clk          (clk),
        .rst          (rst),
        .i_inst_en    (i_inst_en),
        .i_grid_state (i_grid_state),
        .i_instr      (imem_rdata),
        .i_dec        (dec),
        .i_alu_result (alu_result),
        .i_alu_zero   (alu_zero),
        .i_mem_done   (mem_done),
        .i_load_data  (load_data),
        .o_imem_addr  (imem_addr),
        .o_fetch_en   (fetch_en),
        .o_instr      (instr),
        .o_mem_start  (mem_start),
        .o_rf_we      (rf_we),
        .o_rf_waddr   (rf_waddr),
        .o_rf_wdata   (rf_wdata),
        .o_idle       (idle),
        .o_trap       (o_trap),
        .o_busy       (o_busy)
    );

    pe_imem #(.imem_depth(imem_depth)) u_imem (
        .clk        (clk),
        .i_wr       (i_imem_wr),
        .i_wr_allow (idle),
        .i_raddr    (imem_addr),
        .i_ren      (fetch_en),
        .o_rdata    (imem_rdata)
    );

    pe_decode u_decode (.i_instr(instr), .o_dec(dec));

    pe_regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .i_raddr1 (dec.rs1),
        .i_raddr2 (dec.rs2),
        .i_we     (rf_we),
        .i_waddr  (rf_waddr),
        .i_wdata  (rf_wdata),
        .o_rdata1 (rs1_data),
        .o_rdata2 (rs2_data),
        .o_link   (o_link)
    );

    pe_alu u_alu (
        .i_a      (rs1_data),
        .i_b      (alu_b),
        .i_op     (dec.alu_op),
        .o_result (alu_result),
        .o_zero   (alu_zero)
    );

    pe_lsu u_lsu (
        .clk     (clk),
        .rst     (rst),
        .i_start (mem_start),
        .i_we    (dec.is_store),
        .i_addr  (alu_result),
        .i_wdata (rs2_data),
        .i_wb    (i_wb),
        .o_wb    (o_wb),
        .o_done  (mem_done),
        .o_rdata (load_data)
    );

endmodule

`default_nettype wire

// File: logic/pe_control.sv
`timescale 1ns/1ps
`default_nettype none

module pe_control #(
    parameter int n_pe       = 16,
    parameter int pe_id      = 0,
    parameter int reset_pc   = 0,
    parameter int imem_depth = 1024
) (
    input  wire logic                        clk,
    input  wire logic                        rst,
    input  wire logic                        i_inst_en,
    input  wire logic [n_pe-1:0]             i_grid_state,
    input  wire logic [pe_pkg::xlen-1:0]     i_instr,
    input  wire pe_pkg::decoded_t            i_dec,
    input  wire logic [pe_pkg::xlen-1:0]     i_alu_result,
    input  wire logic                        i_alu_zero,
    input  wire logic                        i_mem_done,
    input  wire logic [pe_pkg::xlen-1:0]     i_load_data,
    output logic [$clog2(imem_depth)-1:0]    o_imem_addr,
    output logic                             o_fetch_en,
    output logic [pe_pkg::xlen-1:0]          o_instr,
    output logic                             o_mem_start,
    output logic                             o_rf_we,
    output logic [4:0]                       o_rf_waddr,
    output logic [pe_pkg::xlen-1:0]          o_rf_wdata,
    output logic                             o_idle,
    output logic                             o_trap,
    output logic                             o_busy
);

    import pe_pkg::*;

    localparam int aw = $clog2(imem_depth);
    // addi x0, x0, 0
    localparam logic [xlen-1:0] nop_word = 32'h0000_0013;

    pe_state_t       state;
    logic [aw-1:0]   pc;
    logic [n_pe-1:0] grid_mask;
    logic            stall;
    logic            is_mem;
    logic            exec_commit;
    logic            br_taken;

    // ------------------------------
    // barrier and commit decision
    // ------------------------------

    // own bit never holds the element back
    always_comb begin
        grid_mask        = '1;
        grid_mask[pe_id] = 1'b0;
    end

    assign stall       = |(i_grid_state & grid_mask);
    assign is_mem      = i_dec.is_load | i_dec.is_store;
    assign exec_commit = (state == ST_EXEC) && !is_mem && !stall && !i_dec.illegal;
    assign br_taken    = i_dec.is_branch && (i_alu_zero ^ i_dec.branch_ne);

    // word is only meaningful once fetched
    assign o_instr = (state == ST_EXEC || state == ST_MEM || state == ST_WAIT) ?
                     i_instr : nop_word;

    assign o_imem_addr = pc;
    assign o_fetch_en  = (state == ST_FETCH) && i_inst_en;
    assign o_mem_start = (state == ST_EXEC) && is_mem;

    assign o_rf_we    = (exec_commit && i_dec.reg_write) ||
                        (state == ST_MEM && i_mem_done && i_dec.is_load);
    assign o_rf_waddr = i_dec.rd;
    assign o_rf_wdata = (state == ST_MEM) ? i_load_data : i_alu_result;

    assign o_idle = (state == ST_IDLE);
    assign o_trap = (state == ST_TRAP);
    assign o_busy = (state == ST_MEM) || (state == ST_WAIT);

    // ------------------------------
    // state machine and pc
    // ------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            pc    <= aw'(reset_pc);
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_inst_en) begin
                        state <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    if (i_inst_en) begin
                        state <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    if (is_mem) begin
                        state <= ST_MEM;
                    end else if (stall) begin
                        state <= ST_EXEC;
                    end else if (i_dec.illegal) begin
                        state <= ST_TRAP;
                    end else begin
                        state <= ST_FETCH;
                        // branch offset is in bytes, pc counts words
                        pc <= br_taken ? pc + i_dec.imm[aw+1:2] : pc + 1'b1;
                    end
                end
                ST_MEM: begin
                    if (i_mem_done) begin
                        state <= stall ? ST_WAIT : ST_FETCH;
                        pc    <= pc + 1'b1;
                    end
                end
                ST_WAIT: begin
                    if (!stall) begin
                        state <= ST_FETCH;
                    end
                end
                ST_TRAP: state <= ST_TRAP;
                default: state <= ST_IDLE;
            endcase
        end
    end

    a_no_write_in_wait: assert property (@(posedge clk) disable iff (rst)
        state == ST_WAIT |-> !o_rf_we);

    a_trap_sticky: assert property (@(posedge clk) disable iff (rst)
        state == ST_TRAP |=> state == ST_TRAP);

endmodule

`default_nettype wire

// File: logic/pe_imem.sv
`timescale 1ns/1ps
`default_nettype none

module pe_imem #(
    parameter int imem_depth = 1024
) (
    input  wire logic                          clk,
    input  wire pe_pkg::imem_wr_t              i_wr,
    input  wire logic                          i_wr_allow,
    input  wire logic [$clog2(imem_depth)-1:0] i_raddr,
    input  wire logic                          i_ren,
    output logic [pe_pkg::xlen-1:0]            o_rdata
);

    localparam int aw = $clog2(imem_depth);

    logic [pe_pkg::xlen-1:0] mem [imem_depth];

    // preload only while the core sits idle
    always_ff @(posedge clk) begin
        if (i_wr.we && i_wr_allow) begin
            mem[i_wr.addr[aw-1:0]] <= i_wr.data;
        end
    end

    // output holds between fetches
    always_ff @(posedge clk) begin
        if (i_ren) begin
            o_rdata <= mem[i_raddr];
        end
    end

endmodule

`default_nettype wire

// File: logic/pe_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module pe_lsu (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    i_start,
    input  wire logic                    i_we,
    input  wire logic [pe_pkg::xlen-1:0] i_addr,
    input  wire logic [pe_pkg::xlen-1:0] i_wdata,
    input  wire pe_pkg::wb_rsp_t         i_wb,
    output pe_pkg::wb_req_t              o_wb,
    output logic                         o_done,
    output logic [pe_pkg::xlen-1:0]      o_rdata
);

    logic                    cyc;
    logic                    we_q;
    logic [pe_pkg::xlen-1:0] adr_q;
    logic [pe_pkg::xlen-1:0] dat_q;

    // ------------------------------
    // wishbone classic cycle
    // ------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            cyc    <= 1'b0;
            o_done <= 1'b0;
        end else begin
            o_done <= cyc && i_wb.ack;
            if (cyc && i_wb.ack) begin
                cyc <= 1'b0;
            end else if (i_start) begin
                cyc <= 1'b1;
            end
        end
    end

    // request held stable for the whole cycle
    always_ff @(posedge clk) begin
        if (i_start && !cyc) begin
            we_q  <= i_we;
            adr_q <= i_addr;
            dat_q <= i_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (cyc && i_wb.ack) begin
            o_rdata <= i_wb.dat;
        end
    end

    // whole words only
    assign o_wb.cyc = cyc;
    assign o_wb.stb = cyc;
    assign o_wb.we  = we_q;
    assign o_wb.sel = 4'hf;
    assign o_wb.adr = adr_q;
    assign o_wb.dat = dat_q;

    a_stb_in_cyc: assert property (@(posedge clk) disable iff (rst)
        o_wb.stb |-> o_wb.cyc);

    a_adr_stable: assert property (@(posedge clk) disable iff (rst)
        (o_wb.stb && !i_wb.ack) |=> $stable(o_wb.adr));

endmodule

`default_nettype wire

// File: logic/pe_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module pe_regfile (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic [4:0]              i_raddr1,
    input  wire logic [4:0]              i_raddr2,
    input  wire logic                    i_we,
    input  wire logic [4:0]              i_waddr,
    input  wire logic [pe_pkg::xlen-1:0] i_wdata,
    output logic [pe_pkg::xlen-1:0]      o_rdata1,
    output logic [pe_pkg::xlen-1:0]      o_rdata2,
    output logic [pe_pkg::xlen-1:0]      o_link
);

    // x0 has no storage
    logic [pe_pkg::xlen-1:0] regs [1:31];
    logic                    wr_valid;

    assign wr_valid = i_we && (i_waddr != 5'd0);

    assign o_rdata1 = (i_raddr1 == 5'd0) ? '0 : regs[i_raddr1];
    assign o_rdata2 = (i_raddr2 == 5'd0) ? '0 : regs[i_raddr2];

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // neighbour output follows the last real write
    always_ff @(posedge clk) begin
        if (rst) begin
            o_link <= '0;
        end else if (wr_valid) begin
            o_link <= i_wdata;
        end
    end

endmodule

`default_nettype wire

// File: logic/pe_decode.sv
`timescale 1ns/1ps
`default_nettype none

module pe_decode (
    input  wire logic [pe_pkg::xlen-1:0] i_instr,
    output pe_pkg::decoded_t             o_dec
);

    import pe_pkg::*;

    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [2:0]      funct3;
    alu_op_t         f3_op;

    assign funct3 = i_instr[14:12];

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                    i_instr[30:25], i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};

    // shared by op and op-imm, sub only reachable through op
    always_comb begin
        case (funct3)
            3'b100:  f3_op = ALU_XOR;
            3'b110:  f3_op = ALU_OR;
            3'b111:  f3_op = ALU_AND;
            default: f3_op = ALU_ADD;
        endcase
    end

    always_comb begin
        o_dec         = '0;
        o_dec.rd      = i_instr[11:7];
        o_dec.rs1     = i_instr[19:15];
        o_dec.rs2     = i_instr[24:20];
        o_dec.alu_op  = ALU_ADD;
        o_dec.illegal = (i_instr == '0);
        case (opcode_t'(i_instr[6:0]))
            OPC_LUI: begin
                o_dec.imm       = imm_u;
                o_dec.alu_op    = ALU_PASS_B;
                o_dec.use_imm   = 1'b1;
                o_dec.reg_write = 1'b1;
            end
            OPC_OP_IMM: begin
                o_dec.imm       = imm_i;
                o_dec.alu_op    = f3_op;
                o_dec.use_imm   = 1'b1;
                o_dec.reg_write = 1'b1;
            end
            OPC_OP: begin
                o_dec.alu_op    = (funct3 == 3'b000 && i_instr[30]) ? ALU_SUB : f3_op;
                o_dec.reg_write = 1'b1;
            end
            OPC_BRANCH: begin
                o_dec.imm       = imm_b;
                o_dec.alu_op    = ALU_EQ;
                o_dec.is_branch = 1'b1;
                o_dec.branch_ne = funct3[0];
            end
            OPC_LOAD: begin
                o_dec.imm       = imm_i;
                o_dec.use_imm   = 1'b1;
                o_dec.reg_write = 1'b1;
                o_dec.is_load   = 1'b1;
            end
            OPC_STORE: begin
                o_dec.imm      = imm_s;
                o_dec.use_imm  = 1'b1;
                o_dec.is_store = 1'b1;
            end
            // anything else runs as a nop
            default: o_dec.imm = imm_i;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/pe_alu.sv
`timescale 1ns/1ps
`default_nettype none

module pe_alu (
    input  wire logic [pe_pkg::xlen-1:0] i_a,
    input  wire logic [pe_pkg::xlen-1:0] i_b,
    input  wire pe_pkg::alu_op_t         i_op,
    output logic [pe_pkg::xlen-1:0]      o_result,
    output logic                         o_zero
);

    import pe_pkg::*;

    logic equal;

    assign equal  = (i_a == i_b);
    assign o_zero = equal;

    always_comb begin
        case (i_op)
            ALU_ADD:    o_result = i_a + i_b;
            ALU_SUB:    o_result = i_a - i_b;
            ALU_AND:    o_result = i_a & i_b;
            ALU_OR:     o_result = i_a | i_b;
            ALU_XOR:    o_result = i_a ^ i_b;
            // lui
            ALU_PASS_B: o_result = i_b;
            ALU_EQ:     o_result = {{(xlen-1){1'b0}}, equal};
            default:    o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/pe_pkg.sv
`default_nettype none

package pe_pkg;

    localparam int xlen = 32;

    // ------------------------------
    // encodings
    // ------------------------------

    // rv32i major opcodes kept by the core
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B,
        ALU_EQ
    } alu_op_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_EXEC,
        ST_MEM,
        ST_WAIT,
        ST_TRAP
    } pe_state_t;

    // ------------------------------
    // structs
    // ------------------------------

    typedef struct packed {
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [xlen-1:0] imm;
        alu_op_t         alu_op;
        logic            use_imm;
        logic            reg_write;
        logic            is_branch;
        logic            branch_ne;
        logic            is_load;
        logic            is_store;
        // all-zero instruction word
        logic            illegal;
    } decoded_t;

    // host preload of the instruction memory, addr is a word index
    typedef struct packed {
        logic            we;
        logic [13:0]     addr;
        logic [xlen-1:0] data;
    } imem_wr_t;

    typedef struct packed {
        logic            cyc;
        logic            stb;
        logic            we;
        logic [3:0]      sel;
        logic [xlen-1:0] adr;
        logic [xlen-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic            ack;
        logic [xlen-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire
